/* hdl/rx_capture_pkg.sv */
`default_nettype none

package rx_capture_pkg;

   localparam int NUM_CHAN = 2;
   typedef logic [0:0] chan_t;

   // Settings map, one window per channel
   localparam int SET_BASE   = 160;
   localparam int SET_STRIDE = 4;
   localparam int OFS_TIME   = 0;
   localparam int OFS_CMD    = 1;
   localparam int OFS_CLEAR  = 2;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [31:0] time_t;
   typedef logic [31:0] sample_t;
   typedef logic [20:0] line_count_t;
   typedef logic [8:0]  frame_count_t;

   localparam int CMD_DEPTH = 4;
   localparam int CMD_AW    = $clog2(CMD_DEPTH);
   typedef logic [CMD_AW:0] cmd_level_t;

   localparam int LINE_AW    = 5;
   localparam int LINE_DEPTH = 2 ** LINE_AW;
   typedef logic [LINE_AW:0] level_t;

   // Upper half is the command word as written on the bus
   typedef struct packed {
      logic         send_imm;
      logic         chain;
      line_count_t  numlines;
      frame_count_t lines_per_frame;
      time_t        rcvtime;
   } rx_cmd_t;

   typedef struct packed {
      logic    sop;
      logic    eop;
      sample_t data;
   } rx_line_t;

   typedef struct packed {
      chan_t   chan;
      logic    sop;
      logic    eop;
      sample_t data;
   } rx_word_t;

   typedef enum logic [2:0] {IDLE, WAITING, FIRSTLINE, RUNNING, OVERRUN} ibs_state_t;

endpackage

`default_nettype wire

/* hdl/rx_capture_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_capture_top
(
   input  wire logic                                  clk,
   input  wire logic                                  rst,
   input  wire logic                                  set_stb_i,
   input  wire rx_capture_pkg::set_addr_t             set_addr_i,
   input  wire rx_capture_pkg::set_data_t             set_data_i,
   input  wire rx_capture_pkg::time_t                 master_time_i,
   input  wire rx_capture_pkg::sample_t               sample_i [rx_capture_pkg::NUM_CHAN],
   input  wire logic [rx_capture_pkg::NUM_CHAN-1:0]   strobe_i,
   output rx_capture_pkg::rx_word_t                   out_o,
   output logic                                       out_valid_o,
   input  wire logic                                  out_ready_i,
   output logic [rx_capture_pkg::NUM_CHAN-1:0]        run_o,
   output logic [rx_capture_pkg::NUM_CHAN-1:0]        overrun_o,
   output rx_capture_pkg::level_t                     fifo_level_o [rx_capture_pkg::NUM_CHAN]
);

   rx_capture_pkg::rx_cmd_t               cmd;
   logic [rx_capture_pkg::NUM_CHAN-1:0]   cmd_push;
   logic [rx_capture_pkg::NUM_CHAN-1:0]   clear;
   logic [rx_capture_pkg::NUM_CHAN-1:0]   empty;
   logic [rx_capture_pkg::NUM_CHAN-1:0]   rd;
   rx_capture_pkg::rx_line_t              head [rx_capture_pkg::NUM_CHAN];

   setting_decode u_decode (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .cmd_o      (cmd),
      .cmd_push_o (cmd_push),
      .clear_o    (clear)
   );

   for (genvar c = 0; c < rx_capture_pkg::NUM_CHAN; c++)
   begin : g_chan
      rx_capture_pkg::rx_line_t   line;
      logic                       line_wr;
      logic                       fifo_full;

      rx_stream_ctrl u_ctrl (
         .clk           (clk),
         .rst           (rst),
         .clear_i       (clear[c]),
         .cmd_i         (cmd),
         .cmd_push_i    (cmd_push[c]),
         .master_time_i (master_time_i),
         .sample_i      (sample_i[c]),
         .strobe_i      (strobe_i[c]),
         .fifo_full_i   (fifo_full),
         .line_wr_o     (line_wr),
         .line_o        (line),
         .run_o         (run_o[c]),
         .overrun_o     (overrun_o[c])
      );

      rx_line_fifo u_fifo (
         .clk     (clk),
         .rst     (rst),
         .clear_i (clear[c]),
         .wr_i    (line_wr),
         .din_i   (line),
         .full_o  (fifo_full),
         .rd_i    (rd[c]),
         .dout_o  (head[c]),
         .empty_o (empty[c]),
         .level_o (fifo_level_o[c])
      );
   end

   rx_output_arbiter u_arb (
      .clk         (clk),
      .rst         (rst),
      .head_i      (head),
      .empty_i     (empty),
      .rd_o        (rd),
      .out_o       (out_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

`default_nettype wire

/* hdl/rx_line_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_line_fifo
(
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       clear_i,
   input  wire logic                       wr_i,
   input  wire rx_capture_pkg::rx_line_t   din_i,
   output logic                            full_o,
   input  wire logic                       rd_i,
   output rx_capture_pkg::rx_line_t        dout_o,
   output logic                            empty_o,
   output rx_capture_pkg::level_t          level_o
);

   rx_capture_pkg::rx_line_t              mem [rx_capture_pkg::LINE_DEPTH];
   logic [rx_capture_pkg::LINE_AW-1:0]    wr_ptr;
   logic [rx_capture_pkg::LINE_AW-1:0]    rd_ptr;
   rx_capture_pkg::level_t                count;
   logic                                  do_wr;
   logic                                  do_rd;

   assign full_o  = count == rx_capture_pkg::level_t'(rx_capture_pkg::LINE_DEPTH);
   assign empty_o = count == '0;
   assign level_o = count;

   // Overflow and underflow requests are dropped
   assign do_wr = wr_i && !full_o;
   assign do_rd = rd_i && !empty_o;

   assign dout_o = mem[rd_ptr];   // Fall-through head

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= din_i;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/rx_output_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_output_arbiter
(
   input  wire logic                                  clk,
   input  wire logic                                  rst,
   input  wire rx_capture_pkg::rx_line_t              head_i [rx_capture_pkg::NUM_CHAN],
   input  wire logic [rx_capture_pkg::NUM_CHAN-1:0]   empty_i,
   output logic [rx_capture_pkg::NUM_CHAN-1:0]        rd_o,
   output rx_capture_pkg::rx_word_t                   out_o,
   output logic                                       out_valid_o,
   input  wire logic                                  out_ready_i
);

   rx_capture_pkg::chan_t   grant;
   rx_capture_pkg::chan_t   next_grant;
   logic                    xfer;

   assign out_valid_o = !empty_i[grant];
   assign xfer        = out_valid_o && out_ready_i;

   always_comb
   begin
      out_o.chan = grant;
      out_o.sop  = head_i[grant].sop;
      out_o.eop  = head_i[grant].eop;
      out_o.data = head_i[grant].data;
   end

   always_comb
   begin
      rd_o        = '0;
      rd_o[grant] = xfer;
   end

   // Nearest non-empty channel after the current one, else stay put
   always_comb
   begin
      int idx;
      next_grant = grant;
      for (int i = rx_capture_pkg::NUM_CHAN - 1; i > 0; i--)
      begin
         idx = (int'(grant) + i) % rx_capture_pkg::NUM_CHAN;
         if (!empty_i[idx])
            next_grant = rx_capture_pkg::chan_t'(idx);
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         grant <= '0;
      else if (xfer || !out_valid_o)   // Hold while a word waits
         grant <= next_grant;
   end

endmodule

`default_nettype wire

/* hdl/rx_stream_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_stream_ctrl
(
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       clear_i,
   input  wire rx_capture_pkg::rx_cmd_t    cmd_i,
   input  wire logic                       cmd_push_i,
   input  wire rx_capture_pkg::time_t      master_time_i,
   input  wire rx_capture_pkg::sample_t    sample_i,
   input  wire logic                       strobe_i,
   input  wire logic                       fifo_full_i,
   output logic                            line_wr_o,
   output rx_capture_pkg::rx_line_t        line_o,
   output logic                            run_o,
   output logic                            overrun_o
);

   rx_capture_pkg::rx_cmd_t               cq_mem [rx_capture_pkg::CMD_DEPTH];
   logic [rx_capture_pkg::CMD_AW-1:0]     cq_wr;
   logic [rx_capture_pkg::CMD_AW-1:0]     cq_rd;
   rx_capture_pkg::cmd_level_t            cq_count;
   logic                                  cq_full;
   logic                                  cq_empty;
   logic                                  cq_push;
   logic                                  cq_pop;
   rx_capture_pkg::rx_cmd_t               head;

   rx_capture_pkg::ibs_state_t            state;
   rx_capture_pkg::line_count_t           lines_left;
   rx_capture_pkg::frame_count_t          frame_left;
   rx_capture_pkg::frame_count_t          cur_lpf;
   rx_capture_pkg::time_t                 cur_time;
   logic                                  cur_imm;
   logic                                  cur_chain;

   rx_capture_pkg::time_t                 delta;
   logic                                  go_now;
   logic                                  too_late;
   logic                                  last_line;
   logic                                  last_in_frame;
   logic                                  line_ok;

   assign cq_full  = cq_count == rx_capture_pkg::cmd_level_t'(rx_capture_pkg::CMD_DEPTH);
   assign cq_empty = cq_count == '0;
   assign cq_push  = cmd_push_i && !cq_full;
   assign head     = cq_mem[cq_rd];

   assign last_line     = lines_left == rx_capture_pkg::line_count_t'(1);
   assign last_in_frame = frame_left == rx_capture_pkg::frame_count_t'(1);
   assign line_ok       = (state == rx_capture_pkg::RUNNING) && strobe_i && !fifo_full_i;

   // Load from the queue when idle, or straight on at the end of a chained command
   assign cq_pop = !cq_empty && !clear_i &&
                   ((state == rx_capture_pkg::IDLE) || (line_ok && last_line && cur_chain));

   assign delta    = cur_time - master_time_i;
   assign go_now   = cur_imm || (master_time_i == cur_time);
   assign too_late = delta[31] && !cur_imm;   // Start time already passed

   always_ff @(posedge clk)
   begin
      if (cq_push)
         cq_mem[cq_wr] <= cmd_i;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         cq_wr    <= '0;
         cq_rd    <= '0;
         cq_count <= '0;
      end
      else
      begin
         if (cq_push)
            cq_wr <= cq_wr + 1'b1;
         if (cq_pop)
            cq_rd <= cq_rd + 1'b1;
         case ({cq_push, cq_pop})
            2'b10:   cq_count <= cq_count + 1'b1;
            2'b01:   cq_count <= cq_count - 1'b1;
            default: cq_count <= cq_count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (cq_pop)
      begin
         cur_imm   <= head.send_imm;
         cur_chain <= head.chain;
         cur_lpf   <= head.lines_per_frame;
         cur_time  <= head.rcvtime;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         lines_left <= '0;
         frame_left <= '0;
      end
      else if (cq_pop)
      begin
         lines_left <= head.numlines;
         frame_left <= head.lines_per_frame;
      end
      else if (line_ok)
      begin
         lines_left <= lines_left - 1'b1;
         frame_left <= last_in_frame ? cur_lpf : frame_left - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
         state <= rx_capture_pkg::IDLE;
      else
      begin
         case (state)
            rx_capture_pkg::IDLE:
               if (!cq_empty)
                  state <= rx_capture_pkg::WAITING;
            rx_capture_pkg::WAITING:
               if (go_now)
                  state <= rx_capture_pkg::FIRSTLINE;
               else if (too_late)
                  state <= rx_capture_pkg::OVERRUN;
            rx_capture_pkg::FIRSTLINE:
               if (fifo_full_i || strobe_i)   // No room for a sample before the header
                  state <= rx_capture_pkg::OVERRUN;
               else
                  state <= rx_capture_pkg::RUNNING;
            rx_capture_pkg::RUNNING:
               if (strobe_i && fifo_full_i)
                  state <= rx_capture_pkg::OVERRUN;
               else if (line_ok && last_line)
               begin
                  if (!cur_chain)
                     state <= rx_capture_pkg::IDLE;
                  else if (cq_empty)
                     state <= rx_capture_pkg::OVERRUN;   // Chain broken
                  else
                     state <= rx_capture_pkg::FIRSTLINE;
               end
               else if (line_ok && last_in_frame)
                  state <= rx_capture_pkg::FIRSTLINE;
            rx_capture_pkg::OVERRUN:
               state <= rx_capture_pkg::OVERRUN;   // Sticky until clear
            default:
               state <= rx_capture_pkg::IDLE;
         endcase
      end
   end

   // Header carries the time at which it is written
   always_comb
   begin
      line_o.sop  = state == rx_capture_pkg::FIRSTLINE;
      line_o.eop  = !line_o.sop && (last_line || last_in_frame);
      line_o.data = line_o.sop ? master_time_i : sample_i;
   end

   assign line_wr_o = !fifo_full_i && ((state == rx_capture_pkg::FIRSTLINE) ||
                      ((state == rx_capture_pkg::RUNNING) && strobe_i));

   assign run_o     = (state == rx_capture_pkg::FIRSTLINE) || (state == rx_capture_pkg::RUNNING);
   assign overrun_o = state == rx_capture_pkg::OVERRUN;

endmodule

`default_nettype wire

/* hdl/setting_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module setting_decode
(
   input  wire logic                                  clk,
   input  wire logic                                  rst,
   input  wire logic                                  set_stb_i,
   input  wire rx_capture_pkg::set_addr_t             set_addr_i,
   input  wire rx_capture_pkg::set_data_t             set_data_i,
   output rx_capture_pkg::rx_cmd_t                    cmd_o,
   output logic [rx_capture_pkg::NUM_CHAN-1:0]        cmd_push_o,
   output logic [rx_capture_pkg::NUM_CHAN-1:0]        clear_o
);

   rx_capture_pkg::time_t                 time_q [rx_capture_pkg::NUM_CHAN];
   logic [rx_capture_pkg::NUM_CHAN-1:0]   hit_time;
   logic [rx_capture_pkg::NUM_CHAN-1:0]   hit_cmd;
   logic [rx_capture_pkg::NUM_CHAN-1:0]   hit_clear;

   function automatic logic addr_hit(input int chan, input int ofs,
                                     input rx_capture_pkg::set_addr_t addr);
      return addr == rx_capture_pkg::set_addr_t'(rx_capture_pkg::SET_BASE +
                     chan * rx_capture_pkg::SET_STRIDE + ofs);
   endfunction

   always_comb
   begin
      for (int c = 0; c < rx_capture_pkg::NUM_CHAN; c++)
      begin
         hit_time[c]  = set_stb_i && addr_hit(c, rx_capture_pkg::OFS_TIME, set_addr_i);
         hit_cmd[c]   = set_stb_i && addr_hit(c, rx_capture_pkg::OFS_CMD, set_addr_i);
         hit_clear[c] = set_stb_i && addr_hit(c, rx_capture_pkg::OFS_CLEAR, set_addr_i);
      end
   end

   // Stored time joins the command word on a command write
   always_ff @(posedge clk)
   begin
      for (int c = 0; c < rx_capture_pkg::NUM_CHAN; c++)
      begin
         if (hit_time[c])
            time_q[c] <= set_data_i;
         if (hit_cmd[c])
            cmd_o <= rx_capture_pkg::rx_cmd_t'({set_data_i, time_q[c]});
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cmd_push_o <= '0;
         clear_o    <= '0;
      end
      else
      begin
         cmd_push_o <= hit_cmd;   // One cycle pulses
         clear_o    <= hit_clear;
      end
   end

endmodule

`default_nettype wire

/* sim/rx_capture_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_capture_checker
(
   input  wire logic                                  clk,
   input  wire logic                                  rst,
   input  wire logic [rx_capture_pkg::NUM_CHAN-1:0]   clear_i,
   input  wire rx_capture_pkg::rx_word_t              out_o,
   input  wire logic                                  out_valid_o,
   input  wire logic                                  out_ready_i,
   input  wire logic [rx_capture_pkg::NUM_CHAN-1:0]   run_o,
   input  wire logic [rx_capture_pkg::NUM_CHAN-1:0]   overrun_o
);

   int unsigned fail_count = 0;

   // Offered word holds until taken
   a_out_stable: assert property (@(posedge clk) disable iff (rst)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o))
   else
   begin
      $error("out_o changed while waiting for out_ready_i");
      fail_count++;
   end

   // Quiet outputs on the cycle after reset
   a_reset_quiet: assert property (@(posedge clk)
      $past(rst) |-> run_o == '0 && overrun_o == '0 && !out_valid_o)
   else
   begin
      $error("run_o, overrun_o or out_valid_o high after reset");
      fail_count++;
   end

   for (genvar c = 0; c < rx_capture_pkg::NUM_CHAN; c++)
   begin : g_sticky
      a_overrun_hold: assert property (@(posedge clk) disable iff (rst)
         overrun_o[c] && !clear_i[c] |=> overrun_o[c])
      else
      begin
         $error("overrun_o[%0d] dropped without a clear write", c);
         fail_count++;
      end
   end

endmodule

bind rx_capture_top rx_capture_checker u_chk
(
   .clk         (clk),
   .rst         (rst),
   .clear_i     (clear),
   .out_o       (out_o),
   .out_valid_o (out_valid_o),
   .out_ready_i (out_ready_i),
   .run_o       (run_o),
   .overrun_o   (overrun_o)
);

`default_nettype wire

/* sim/rx_capture_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rx_capture_tb;

   localparam int NCH     = rx_capture_pkg::NUM_CHAN;
   localparam int TIMEOUT = 3000;

   logic                           clk;
   logic                           rst;
   logic                           set_stb_i;
   rx_capture_pkg::set_addr_t      set_addr_i;
   rx_capture_pkg::set_data_t      set_data_i;
   rx_capture_pkg::time_t          master_time_i;
   rx_capture_pkg::sample_t        sample_i [NCH];
   logic [NCH-1:0]                 strobe_i;
   rx_capture_pkg::rx_word_t       out_o;
   logic                           out_valid_o;
   logic                           out_ready_i;
   logic [NCH-1:0]                 run_o;
   logic [NCH-1:0]                 overrun_o;
   rx_capture_pkg::level_t         fifo_level_o [NCH];

   // Reference model, one set per channel
   rx_capture_pkg::ibs_state_t     m_state [NCH];
   rx_capture_pkg::rx_cmd_t        m_cmdq [NCH][$];
   rx_capture_pkg::rx_line_t       m_expq [NCH][$];
   rx_capture_pkg::rx_cmd_t        m_cur [NCH];
   rx_capture_pkg::line_count_t    m_lines [NCH];
   rx_capture_pkg::frame_count_t   m_frame [NCH];
   int                             m_fill [NCH];
   rx_capture_pkg::time_t          m_time [NCH];
   rx_capture_pkg::rx_cmd_t        m_cmd;
   logic [NCH-1:0]                 m_push;
   logic [NCH-1:0]                 m_clear;

   logic [NCH-1:0]                 strobe_nx;
   rx_capture_pkg::sample_t        sample_nx [NCH];
   logic                           ready_nx;
   logic                           stall;
   int                             errors;
   int                             test_base;
   int                             tests_run;
   int                             tests_failed;
   string                          test_name;

   rx_capture_top uut (
      .clk           (clk),
      .rst           (rst),
      .set_stb_i     (set_stb_i),
      .set_addr_i    (set_addr_i),
      .set_data_i    (set_data_i),
      .master_time_i (master_time_i),
      .sample_i      (sample_i),
      .strobe_i      (strobe_i),
      .out_o         (out_o),
      .out_valid_o   (out_valid_o),
      .out_ready_i   (out_ready_i),
      .run_o         (run_o),
      .overrun_o     (overrun_o),
      .fifo_level_o  (fifo_level_o)
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      master_time_i <= master_time_i + 1'b1;
      strobe_i      <= strobe_nx;
      sample_i      <= sample_nx;
      out_ready_i   <= ready_nx;
   end

   task automatic report_value(input string sig, input logic [63:0] exp, input logic [63:0] got);
      $display("ERR %0t %s exp=%0h got=%0h", $time, sig, exp, got);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("%0t %s", $time, msg);
      errors++;
   endtask

   task automatic abort_on_timeout(input string what);
      $display("%0t timeout: %s", $time, what);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   // Outputs seen at the falling edge, before the model takes the next step
   task automatic check_outputs();
      rx_capture_pkg::rx_line_t exp;
      int                       c;
      if (!rst)
      begin
         for (int i = 0; i < NCH; i++)
         begin
            assert (run_o[i] == (m_state[i] == rx_capture_pkg::FIRSTLINE ||
                                 m_state[i] == rx_capture_pkg::RUNNING))
            else report_value($sformatf("run_o[%0d]", i), !run_o[i], run_o[i]);
            assert (overrun_o[i] == (m_state[i] == rx_capture_pkg::OVERRUN))
            else report_value($sformatf("overrun_o[%0d]", i), !overrun_o[i], overrun_o[i]);
         end
         if (out_valid_o)
         begin
            c = int'(out_o.chan);
            assert (m_expq[c].size() != 0)
            else report_failure($sformatf("word offered on channel %0d with none expected", c));
            if (out_ready_i && m_expq[c].size() != 0)
            begin
               exp = m_expq[c].pop_front();
               assert ({out_o.sop, out_o.eop, out_o.data} == exp)
               else report_value($sformatf("out_o ch%0d", c), exp,
                                 {out_o.sop, out_o.eop, out_o.data});
            end
         end
      end
   endtask

   // One clock edge of the capture rules
   task automatic step_model();
      logic                        full;
      logic                        rd;
      logic                        line_ok;
      logic                        last_line;
      logic                        last_frame;
      logic                        pop;
      logic                        push_ok;
      rx_capture_pkg::rx_line_t    line;
      rx_capture_pkg::time_t       diff;
      rx_capture_pkg::set_addr_t   base;
      for (int c = 0; c < NCH; c++)
      begin
         rd   = !rst && out_valid_o && out_ready_i && (int'(out_o.chan) == c);
         full = m_fill[c] == rx_capture_pkg::LINE_DEPTH;
         if (rst || m_clear[c])
         begin
            m_state[c] = rx_capture_pkg::IDLE;
            m_cmdq[c].delete();
            m_expq[c].delete();
            m_fill[c]  = 0;
            m_lines[c] = '0;
            m_frame[c] = '0;
            continue;
         end
         line_ok    = m_state[c] == rx_capture_pkg::RUNNING && strobe_i[c] && !full;
         last_line  = m_lines[c] == 1;
         last_frame = m_frame[c] == 1;
         push_ok    = m_push[c] && m_cmdq[c].size() < rx_capture_pkg::CMD_DEPTH;
         pop = m_cmdq[c].size() != 0 && (m_state[c] == rx_capture_pkg::IDLE ||
                                          (line_ok && last_line && m_cur[c].chain));
         if (m_state[c] == rx_capture_pkg::FIRSTLINE && !full)
         begin
            line = '{sop: 1'b1, eop: 1'b0, data: master_time_i};   // Header
            m_expq[c].push_back(line);
            m_fill[c]++;
         end
         if (line_ok)
         begin
            line = '{sop: 1'b0, eop: last_line || last_frame, data: sample_i[c]};
            m_expq[c].push_back(line);
            m_fill[c]++;
         end
         diff = m_cur[c].rcvtime - master_time_i;
         case (m_state[c])
            rx_capture_pkg::IDLE:
               if (m_cmdq[c].size() != 0)
                  m_state[c] = rx_capture_pkg::WAITING;
            rx_capture_pkg::WAITING:
               if (m_cur[c].send_imm || diff == '0)
                  m_state[c] = rx_capture_pkg::FIRSTLINE;
               else if (diff[31])
                  m_state[c] = rx_capture_pkg::OVERRUN;
            rx_capture_pkg::FIRSTLINE:
               m_state[c] = (full || strobe_i[c]) ? rx_capture_pkg::OVERRUN :
                                                    rx_capture_pkg::RUNNING;
            rx_capture_pkg::RUNNING:
               if (strobe_i[c] && full)
                  m_state[c] = rx_capture_pkg::OVERRUN;
               else if (line_ok && last_line && !m_cur[c].chain)
                  m_state[c] = rx_capture_pkg::IDLE;
               else if (line_ok && last_line)
                  m_state[c] = pop ? rx_capture_pkg::FIRSTLINE : rx_capture_pkg::OVERRUN;
               else if (line_ok && last_frame)
                  m_state[c] = rx_capture_pkg::FIRSTLINE;
            default:
               m_state[c] = m_state[c];
         endcase
         if (pop)
         begin
            m_cur[c]   = m_cmdq[c].pop_front();
            m_lines[c] = m_cur[c].numlines;
            m_frame[c] = m_cur[c].lines_per_frame;
         end
         else if (line_ok)
         begin
            m_lines[c] = m_lines[c] - 1'b1;
            m_frame[c] = last_frame ? m_cur[c].lines_per_frame : m_frame[c] - 1'b1;
         end
         if (push_ok)
            m_cmdq[c].push_back(m_cmd);
         if (rd)
            m_fill[c]--;
      end
      // Settings decode, one cycle behind the bus
      for (int c = 0; c < NCH; c++)
      begin
         base       = rx_capture_pkg::set_addr_t'(rx_capture_pkg::SET_BASE +
                                                  c * rx_capture_pkg::SET_STRIDE);
         m_push[c]  = !rst && set_stb_i && set_addr_i == base + rx_capture_pkg::OFS_CMD;
         m_clear[c] = !rst && set_stb_i && set_addr_i == base + rx_capture_pkg::OFS_CLEAR;
         if (m_push[c])
            m_cmd = {set_data_i, m_time[c]};
         if (set_stb_i && set_addr_i == base + rx_capture_pkg::OFS_TIME)
            m_time[c] = set_data_i;
      end
   endtask

   initial
   begin
      void'($urandom(32'hc924_2c11));
      forever
      begin
         @(negedge clk);
         check_outputs();
         step_model();
         for (int c = 0; c < NCH; c++)
         begin
            strobe_nx[c] = m_state[c] == rx_capture_pkg::RUNNING && $urandom_range(3) == 0;
            sample_nx[c] = $urandom;
         end
         ready_nx = !stall && $urandom_range(3) != 0;
      end
   end

   task automatic write_setting(input int c, input int ofs, input rx_capture_pkg::set_data_t data);
      @(posedge clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= rx_capture_pkg::set_addr_t'(rx_capture_pkg::SET_BASE +
                                                c * rx_capture_pkg::SET_STRIDE + ofs);
      set_data_i <= data;
      @(posedge clk);
      set_stb_i  <= 1'b0;
   endtask

   task automatic queue_command(input int c, input logic imm, input logic chain,
                                input int lines, input int lpf);
      write_setting(c, rx_capture_pkg::OFS_CMD, {imm, chain, rx_capture_pkg::line_count_t'(lines),
                                                 rx_capture_pkg::frame_count_t'(lpf)});
   endtask

   function automatic logic all_idle();
      logic idle;
      idle = !out_valid_o && m_push == '0;
      for (int c = 0; c < NCH; c++)
         idle = idle && m_state[c] == rx_capture_pkg::IDLE && m_cmdq[c].size() == 0 &&
                m_expq[c].size() == 0;
      return idle;
   endfunction

   task automatic settle_all();
      int n;
      n = 0;
      while (!all_idle() && n < TIMEOUT)
      begin
         @(posedge clk);
         n++;
      end
      if (!all_idle())
         abort_on_timeout("channels did not finish and drain");
   endtask

   task automatic await_overrun(input int c);
      int n;
      n = 0;
      while (!overrun_o[c] && n < TIMEOUT)
      begin
         @(posedge clk);
         n++;
      end
      if (!overrun_o[c])
         abort_on_timeout($sformatf("channel %0d never reported overrun", c));
   endtask

   task automatic drain_channel(input int c);
      int n;
      n = 0;
      while ((m_expq[c].size() != 0 || out_valid_o) && n < TIMEOUT)
      begin
         @(posedge clk);
         n++;
      end
      if (m_expq[c].size() != 0 || out_valid_o)
         abort_on_timeout($sformatf("channel %0d words never drained", c));
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_base = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == test_base)
         $display("test %0d %s: ok", tests_run, test_name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: failed, %0d errors", tests_run, test_name, errors - test_base);
      end
   endtask

   initial
   begin
      rx_capture_pkg::time_t t;
      int                    n;
      clk           = 1'b0;
      rst           = 1'b1;
      set_stb_i     = 1'b0;
      set_addr_i    = '0;
      set_data_i    = '0;
      master_time_i = 32'h0000_1000;
      strobe_i      = '0;
      strobe_nx     = '0;
      out_ready_i   = 1'b0;
      ready_nx      = 1'b0;
      stall         = 1'b0;
      for (int c = 0; c < NCH; c++)
      begin
         sample_i[c]  = '0;
         sample_nx[c] = '0;
      end
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      repeat (3) @(posedge clk);

      begin_test("immediate multi-frame");
      queue_command(0, 1'b1, 1'b0, 10, 4);
      settle_all();
      finish_test();

      begin_test("timed start");
      t = master_time_i + 60;
      write_setting(1, rx_capture_pkg::OFS_TIME, t);
      queue_command(1, 1'b0, 1'b0, 6, 3);
      n = 0;
      while (!run_o[1] && n < TIMEOUT)
      begin
         @(posedge clk);
         n++;
      end
      if (!run_o[1])
         abort_on_timeout("timed command never started");
      // Capture opens on the tick after the match
      assert (master_time_i == t + 1)
      else report_value("master_time_i at start", t + 1, master_time_i);
      settle_all();
      finish_test();

      begin_test("late start and clear");
      t = master_time_i - 50;
      write_setting(0, rx_capture_pkg::OFS_TIME, t);
      queue_command(0, 1'b0, 1'b0, 5, 5);
      await_overrun(0);
      assert (m_expq[0].size() == 0 && !out_valid_o)
      else report_failure("late command produced output words");
      write_setting(0, rx_capture_pkg::OFS_CLEAR, '0);
      queue_command(0, 1'b1, 1'b0, 5, 5);
      settle_all();
      finish_test();

      begin_test("chained commands");
      queue_command(1, 1'b1, 1'b1, 6, 3);
      queue_command(1, 1'b1, 1'b0, 4, 4);
      settle_all();
      queue_command(1, 1'b1, 1'b1, 3, 3);   // Nothing queued behind it
      await_overrun(1);
      drain_channel(1);
      write_setting(1, rx_capture_pkg::OFS_CLEAR, '0);
      settle_all();
      finish_test();

      begin_test("both channels and back-pressure");
      queue_command(0, 1'b1, 1'b0, 40, 8);
      queue_command(1, 1'b1, 1'b0, 40, 10);
      settle_all();
      stall = 1'b1;
      queue_command(0, 1'b1, 1'b0, 100, 50);
      await_overrun(0);
      assert (fifo_level_o[0] == rx_capture_pkg::LINE_DEPTH)
      else report_value("fifo_level_o[0]", rx_capture_pkg::LINE_DEPTH, fifo_level_o[0]);
      stall = 1'b0;
      drain_channel(0);
      write_setting(0, rx_capture_pkg::OFS_CLEAR, '0);
      settle_all();
      finish_test();

      $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
               tests_run, tests_failed, errors, uut.u_chk.fail_count);
      if (errors == 0 && uut.u_chk.fail_count == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
hdl/rx_capture_pkg.sv
hdl/setting_decode.sv
hdl/rx_line_fifo.sv
hdl/rx_stream_ctrl.sv
hdl/rx_output_arbiter.sv
hdl/rx_capture_top.sv
sim/rx_capture_checker.sv
sim/rx_capture_tb.sv
